// File: aluDecoder.sv
`timescale 1ns/10ps

module aluDecoder import ctrlPkg::*; (
	input opcode_e op,
	input funct_e funct,
	input logic [RegWidth-1:0] rt,
	output aluOp_e aluOp,
	output extOp_e extOp,
	output logic shamtSel,
	output logic immSrc,
	output logic aluKnown
);

	logic isMemOp;

	assign isMemOp = op inside {OpLb, OpLh, OpLwl, OpLw, OpLbu, OpLhu, OpLwr, OpLl,
		OpSb, OpSh, OpSwl, OpSw, OpSwr, OpSc};

	always_comb begin
		aluOp = AluNone;
		aluKnown = 1'b1;
		case (op)
			OpSpecial:
				case (funct)
					FnAdd: aluOp = AluAdd;
					FnAddu: aluOp = AluAddu;
					FnSub: aluOp = AluSub;
					FnSubu: aluOp = AluSubu;
					FnAnd: aluOp = AluAnd;
					FnOr: aluOp = AluOr;
					FnXor: aluOp = AluXor;
					FnNor: aluOp = AluNor;
					FnSll, FnSllv: aluOp = AluSll;
					FnSrl, FnSrlv: aluOp = AluSrl;
					FnSra, FnSrav: aluOp = AluSra;
					FnSlt: aluOp = AluSlt;
					FnSltu: aluOp = AluSltu;
					FnMovz, FnMovn: aluOp = AluMov; // Condition checked at write-back
					default: aluKnown = 1'b0;
				endcase
			OpSpecial2:
				case (funct)
					FnClo: aluOp = AluClo;
					FnClz: aluOp = AluClz;
					default: aluKnown = 1'b0;
				endcase
			OpAddi: aluOp = AluAdd;
			OpAddiu: aluOp = AluAddu;
			OpSlti: aluOp = AluSlt;
			OpSltiu: aluOp = AluSltu;
			OpAndi: aluOp = AluAnd;
			OpOri: aluOp = AluOr;
			OpXori: aluOp = AluXor;
			OpLui: aluOp = AluNone;     // Value comes straight from the extender
			default: begin
				aluOp = isMemOp ? AluAdd : AluNone; // Address calculation
				aluKnown = 1'b0;
			end
		endcase
		// Result would only reach $0, so leave the ALU idle
		if (rt == '0 && op inside {OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori})
			aluOp = AluNone;
	end

	always_comb begin
		if (isMemOp || op inside {OpAddi, OpAddiu, OpSlti, OpSltiu})
			extOp = ExtSign;
		else if (op == OpLui)
			extOp = ExtUpper;
		else
			extOp = ExtZero;
	end

	assign shamtSel = (op == OpSpecial) && (funct inside {FnSll, FnSrl, FnSra});
	assign immSrc = (op != OpSpecial);

endmodule

// File: branchUnit.sv
`timescale 1ns/10ps

module branchUnit import ctrlPkg::*; (
	input opcode_e op,
	input funct_e funct,
	input logic [RegWidth-1:0] rs,
	input logic [RegWidth-1:0] rt,
	input logic rsNeRt,
	input logic rsGez,
	input logic rsLtz,
	input logic rsLez,
	input logic rsGtz,
	output logic isBranch,
	output npcOp_e npcOp,
	output brHint_e brHint,
	output jType_e jType,
	output logic branchKnown
);

	brCond_e brCond;
	logic taken;
	logic isCall;

	always_comb begin
		case (op)
			OpBeq: brCond = CondEq;
			OpBne: brCond = CondNe;
			OpBlez: brCond = CondLez;
			OpBgtz: brCond = CondGtz;
			OpRegImm:
				case (rt)
					RtBgez, RtBgezal: brCond = CondGez;
					RtBltz, RtBltzal: brCond = CondLtz;
					default: brCond = CondNotBranch;
				endcase
			default: brCond = CondNotBranch;
		endcase
	end

	always_comb begin
		if (op == OpJ || op == OpJal)
			jType = JDirect;
		else if (op == OpSpecial && funct inside {FnJr, FnJalr})
			jType = JRegister;
		else
			jType = JNone;
	end

	// Compare flags arrive resolved from the register read
	always_comb begin
		case (brCond)
			CondEq: taken = !rsNeRt;
			CondNe: taken = rsNeRt;
			CondGez: taken = rsGez;
			CondLtz: taken = rsLtz;
			CondLez: taken = rsLez;
			CondGtz: taken = rsGtz;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (jType)
			JDirect: npcOp = NpcJump;
			JRegister: npcOp = NpcJumpReg;
			default: npcOp = taken ? NpcBranch : NpcSeq;
		endcase
	end

	assign isBranch = (brCond != CondNotBranch) || (jType != JNone);
	assign isCall = (op == OpJal) || (op == OpRegImm && rt inside {RtBgezal, RtBltzal});

	// Hints for the return stack of the predictor
	always_comb begin
		if (!isBranch)
			brHint = HintNone;
		else if (isCall)
			brHint = HintCall;
		else if (op == OpSpecial && funct == FnJr && rs == RegWidth'(31))
			brHint = HintReturn;
		else
			brHint = HintOther;
	end

	assign branchKnown = isBranch;

endmodule

// File: ctrlPkg.sv
package ctrlPkg;

	localparam int OpWidth = 6;
	localparam int RegWidth = 5;
	localparam int FunctWidth = 6;

	// RegImm branch selectors, carried in the rt field
	localparam logic [RegWidth-1:0] RtBltz = 5'b00000;
	localparam logic [RegWidth-1:0] RtBgez = 5'b00001;
	localparam logic [RegWidth-1:0] RtBltzal = 5'b10000;
	localparam logic [RegWidth-1:0] RtBgezal = 5'b10001;

	typedef enum logic [OpWidth-1:0] {
		OpSpecial = 6'b000000, OpRegImm = 6'b000001, OpJ = 6'b000010, OpJal = 6'b000011,
		OpBeq = 6'b000100, OpBne = 6'b000101, OpBlez = 6'b000110, OpBgtz = 6'b000111,
		OpAddi = 6'b001000, OpAddiu = 6'b001001, OpSlti = 6'b001010, OpSltiu = 6'b001011,
		OpAndi = 6'b001100, OpOri = 6'b001101, OpXori = 6'b001110, OpLui = 6'b001111,
		OpSpecial2 = 6'b011100,
		OpLb = 6'b100000, OpLh = 6'b100001, OpLwl = 6'b100010, OpLw = 6'b100011,
		OpLbu = 6'b100100, OpLhu = 6'b100101, OpLwr = 6'b100110,
		OpSb = 6'b101000, OpSh = 6'b101001, OpSwl = 6'b101010, OpSw = 6'b101011,
		OpSwr = 6'b101110, OpLl = 6'b110000, OpSc = 6'b111000
	} opcode_e;

	// Special function codes
	typedef enum logic [FunctWidth-1:0] {
		FnSll = 6'd0, FnSrl = 6'd2, FnSra = 6'd3, FnSllv = 6'd4, FnSrlv = 6'd6, FnSrav = 6'd7,
		FnJr = 6'd8, FnJalr = 6'd9, FnMovz = 6'd10, FnMovn = 6'd11,
		FnSyscall = 6'd12, FnBreak = 6'd13, FnSync = 6'd15,
		FnMfhi = 6'd16, FnMthi = 6'd17, FnMflo = 6'd18, FnMtlo = 6'd19,
		FnMult = 6'd24, FnMultu = 6'd25, FnDiv = 6'd26, FnDivu = 6'd27,
		FnAdd = 6'd32, FnAddu = 6'd33, FnSub = 6'd34, FnSubu = 6'd35,
		FnAnd = 6'd36, FnOr = 6'd37, FnXor = 6'd38, FnNor = 6'd39, FnSlt = 6'd42, FnSltu = 6'd43
	} funct_e;

	// Special2 function codes, sharing the Special code space
	localparam funct_e FnMadd = funct_e'(6'd0);
	localparam funct_e FnMaddu = funct_e'(6'd1);
	localparam funct_e FnMul = funct_e'(6'd2);
	localparam funct_e FnMsub = funct_e'(6'd4);
	localparam funct_e FnMsubu = funct_e'(6'd5);
	localparam funct_e FnClz = funct_e'(6'd32);
	localparam funct_e FnClo = funct_e'(6'd33);

	typedef enum logic [4:0] {
		AluAdd = 5'd0, AluSub = 5'd1, AluOr = 5'd2, AluAnd = 5'd3, AluNor = 5'd4,
		AluXor = 5'd5, AluSll = 5'd6, AluSrl = 5'd7, AluSra = 5'd8, AluSlt = 5'd9,
		AluSltu = 5'd10, AluMov = 5'd11, AluAddu = 5'd12, AluClo = 5'd13, AluClz = 5'd14,
		AluSubu = 5'd16, AluNone = 5'b11111
	} aluOp_e;

	typedef enum logic [3:0] {
		MdMultu, MdMult, MdDivu, MdDiv, MdMaddu, MdMadd, MdMsub, MdMsubu, MdMul
	} mdOp_e;

	typedef enum logic [3:0] {
		MemSb, MemSh, MemSw, MemSwl, MemSwr, MemLbu, MemLb, MemLhu, MemLh, MemLwl, MemLwr, MemLw
	} memSel_e;

	typedef enum logic [1:0] {ExtZero, ExtSign, ExtUpper} extOp_e;
	typedef enum logic [1:0] {DstRt, DstRd, DstRa31} dstSel_e;
	typedef enum logic [2:0] {WbHiLo, WbImm, WbAlu, WbLink, WbMem, WbSc = 3'd7} wbSel_e;
	typedef enum logic [1:0] {NpcSeq, NpcBranch, NpcJump, NpcJumpReg} npcOp_e;
	typedef enum logic [1:0] {HintNone, HintReturn, HintOther, HintCall} brHint_e;
	typedef enum logic [1:0] {JNone, JDirect, JRegister} jType_e;

	typedef enum logic [2:0] {
		CondEq, CondNe, CondGez, CondLtz, CondLez, CondGtz, CondNotBranch = 3'd7
	} brCond_e;

	typedef enum logic [4:0] {
		ExcNone = 5'd0, ExcSys = 5'd8, ExcBp = 5'd9, ExcRi = 5'd10
	} excCode_e;

endpackage

// File: decodeStage.sv
`timescale 1ns/10ps

module decodeStage import ctrlPkg::*; (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input logic [31:0] instr,
	input logic rsNeRt, rsGez, rsLtz, rsLez, rsGtz, rtZero,
	input logic fetchExc,
	input excCode_e fetchExcCode,
	output logic outValid,
	input logic outReady,
	output aluOp_e aluOp,
	output extOp_e extOp,
	output logic shamtSel, immSrc,
	output logic memWrite, memRead, llFlag, scFlag,
	output memSel_e memSel,
	output logic hiloWrite, hiloRdHi, mdStart, hiloAccess,
	output logic [1:0] hiloWrSel,
	output mdOp_e mdOp,
	output logic isBranch,
	output npcOp_e npcOp,
	output brHint_e brHint,
	output jType_e jType,
	output logic regWrite,
	output dstSel_e dstSel,
	output wbSel_e wbSel,
	output logic excValid,
	output excCode_e excCode
);

	opcode_e op;
	funct_e funct;
	logic [RegWidth-1:0] rs, rt;
	logic load;

	// Decoder results ahead of the output register
	aluOp_e aluOpNxt;
	extOp_e extOpNxt;
	memSel_e memSelNxt;
	mdOp_e mdOpNxt;
	npcOp_e npcOpNxt;
	brHint_e brHintNxt;
	jType_e jTypeNxt;
	dstSel_e dstSelNxt;
	wbSel_e wbSelNxt;
	excCode_e excCodeNxt;
	logic [1:0] hiloWrSelNxt;
	logic shamtSelNxt, immSrcNxt, memWriteNxt, memReadNxt, llFlagNxt, scFlagNxt;
	logic hiloWriteNxt, hiloRdHiNxt, mdStartNxt, hiloAccessNxt, isBranchNxt;
	logic regWriteNxt, excValidNxt;
	logic aluKnown, memKnown, mdKnown, branchKnown;

	assign op = opcode_e'(instr[31 -: OpWidth]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign funct = funct_e'(instr[FunctWidth-1:0]);

	aluDecoder i_aluDecoder (.op(op), .funct(funct), .rt(rt), .aluOp(aluOpNxt),
		.extOp(extOpNxt), .shamtSel(shamtSelNxt), .immSrc(immSrcNxt), .aluKnown(aluKnown));

	memDecoder i_memDecoder (.op(op), .memWrite(memWriteNxt), .memRead(memReadNxt),
		.memSel(memSelNxt), .llFlag(llFlagNxt), .scFlag(scFlagNxt), .memKnown(memKnown));

	mulDivDecoder i_mulDivDecoder (.op(op), .funct(funct), .hiloWrite(hiloWriteNxt),
		.hiloWrSel(hiloWrSelNxt), .hiloRdHi(hiloRdHiNxt), .mdStart(mdStartNxt),
		.mdOp(mdOpNxt), .hiloAccess(hiloAccessNxt), .mdKnown(mdKnown));

	branchUnit i_branchUnit (.op(op), .funct(funct), .rs(rs), .rt(rt), .rsNeRt(rsNeRt),
		.rsGez(rsGez), .rsLtz(rsLtz), .rsLez(rsLez), .rsGtz(rsGtz), .isBranch(isBranchNxt),
		.npcOp(npcOpNxt), .brHint(brHintNxt), .jType(jTypeNxt), .branchKnown(branchKnown));

	writebackDecoder i_writebackDecoder (.op(op), .funct(funct), .rt(rt), .rtZero(rtZero),
		.regWrite(regWriteNxt), .dstSel(dstSelNxt), .wbSel(wbSelNxt));

	exceptionCheck i_exceptionCheck (.op(op), .funct(funct), .fetchExc(fetchExc),
		.fetchExcCode(fetchExcCode), .anyKnown(aluKnown | memKnown | mdKnown | branchKnown),
		.excValid(excValidNxt), .excCode(excCodeNxt));

	assign inReady = !outValid || outReady;  // Empty or draining this cycle
	assign load = inValid && inReady;

	always_ff @(posedge clk) begin
		if (!rst) begin
			outValid <= 1'b0;
			{regWrite, hiloWrite, memWrite, memRead, mdStart, excValid} <= '0;
			npcOp <= NpcSeq;
		end else begin
			if (inReady)
				outValid <= inValid;
			if (load) begin
				{regWrite, hiloWrite, memWrite, memRead, mdStart, excValid} <= {regWriteNxt,
					hiloWriteNxt, memWriteNxt, memReadNxt, mdStartNxt, excValidNxt};
				npcOp <= npcOpNxt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			{shamtSel, immSrc, llFlag, scFlag, hiloRdHi, hiloAccess, isBranch} <= {shamtSelNxt,
				immSrcNxt, llFlagNxt, scFlagNxt, hiloRdHiNxt, hiloAccessNxt, isBranchNxt};
			hiloWrSel <= hiloWrSelNxt;
			aluOp <= aluOpNxt;
			extOp <= extOpNxt;
			memSel <= memSelNxt;
			mdOp <= mdOpNxt;
			brHint <= brHintNxt;
			jType <= jTypeNxt;
			dstSel <= dstSelNxt;
			wbSel <= wbSelNxt;
			excCode <= excCodeNxt;
		end
	end

	assert property (@(posedge clk) disable iff (!rst) outValid |-> !(memWrite && memRead))
		else $error("memory read and write raised together");

	// Execute stage may sample any cycle, so a stalled item must not change
	assert property (@(posedge clk) disable iff (!rst)
		outValid && !outReady |=> outValid && $stable({aluOp, extOp, shamtSel, immSrc,
			memWrite, memRead, memSel, llFlag, scFlag, hiloWrite, hiloWrSel, hiloRdHi, mdStart,
			mdOp, hiloAccess, isBranch, npcOp, brHint, jType, regWrite, dstSel, wbSel,
			excValid, excCode}))
		else $error("decoded item changed under back-pressure");

endmodule

// File: decodeTbTasks.svh
`ifndef DECODE_TB_TASKS_SVH
`define DECODE_TB_TASKS_SVH

// Drives one word a little after the edge and holds it until the stage takes it
task automatic sendInstr(input logic [31:0] word, input logic [5:0] flags, input logic fExc,
		input excCode_e fCode);
	@(posedge clk);
	#5;
	instr = word;
	{rsNeRt, rsGez, rsLtz, rsLez, rsGtz, rtZero} = flags;
	fetchExc = fExc;
	fetchExcCode = fCode;
	inValid = 1'b1;
	while (!inReady) begin
		@(posedge clk);
		#5;
	end
	@(posedge clk);  // Accepting edge
	#5;
	inValid = 1'b0;
	checkBit("outValid", outValid, 1'b1);
endtask

task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	errors++;
	$display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkWrSel(input string name, input logic [1:0] got, input logic [1:0] exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkAlu(input string name, input aluOp_e got, input aluOp_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkExt(input string name, input extOp_e got, input extOp_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkMem(input string name, input memSel_e got, input memSel_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkMd(input string name, input mdOp_e got, input mdOp_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkDst(input string name, input dstSel_e got, input dstSel_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkWb(input string name, input wbSel_e got, input wbSel_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkNpc(input string name, input npcOp_e got, input npcOp_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkHint(input string name, input brHint_e got, input brHint_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkJType(input string name, input jType_e got, input jType_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

task automatic checkExc(input string name, input excCode_e got, input excCode_e exp);
	checks++;
	if (got !== exp)
		reportMismatch(name, 32'(got), 32'(exp));
endtask

`endif

// File: decodeStageTb.sv
`timescale 1ns/10ps

module decodeStageTb import ctrlPkg::*; ();

	localparam int Period = 40;
	localparam int NumTests = 6;
	localparam int Seed = 32'h66af1e67;

	logic clk, rst, inValid, inReady, outValid, outReady;
	logic [31:0] instr;
	logic rsNeRt, rsGez, rsLtz, rsLez, rsGtz, rtZero;
	logic fetchExc;
	excCode_e fetchExcCode;
	aluOp_e aluOp;
	extOp_e extOp;
	logic shamtSel, immSrc, memWrite, memRead, llFlag, scFlag;
	memSel_e memSel;
	logic hiloWrite, hiloRdHi, mdStart, hiloAccess;
	logic [1:0] hiloWrSel;
	mdOp_e mdOp;
	logic isBranch;
	npcOp_e npcOp;
	brHint_e brHint;
	jType_e jType;
	logic regWrite;
	dstSel_e dstSel;
	wbSel_e wbSel;
	logic excValid;
	excCode_e excCode;

	int checks = 0;
	int errors = 0;

	// Expected ALU decode, R-type by funct and I-type by opcode
	funct_e rFns [16] = '{FnAdd, FnAddu, FnSub, FnSubu, FnAnd, FnOr, FnXor, FnNor,
		FnSllv, FnSrlv, FnSrav, FnSlt, FnSltu, FnSll, FnSrl, FnSra};
	aluOp_e rAlus [16] = '{AluAdd, AluAddu, AluSub, AluSubu, AluAnd, AluOr, AluXor, AluNor,
		AluSll, AluSrl, AluSra, AluSlt, AluSltu, AluSll, AluSrl, AluSra};
	opcode_e iOps [8] = '{OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui};
	aluOp_e iAlus [8] = '{AluAdd, AluAddu, AluSlt, AluSltu, AluAnd, AluOr, AluXor, AluNone};
	extOp_e iExts [8] = '{ExtSign, ExtSign, ExtSign, ExtSign, ExtZero, ExtZero, ExtZero,
		ExtUpper};
	// Loads first, then stores
	opcode_e memOps [14] = '{OpLb, OpLh, OpLwl, OpLw, OpLbu, OpLhu, OpLwr, OpLl,
		OpSb, OpSh, OpSwl, OpSw, OpSwr, OpSc};
	memSel_e memSels [14] = '{MemLb, MemLh, MemLwl, MemLw, MemLbu, MemLhu, MemLwr, MemLw,
		MemSb, MemSh, MemSwl, MemSw, MemSwr, MemSw};

	decodeStage i_decodeStage (.*);

	`include "decodeTbTasks.svh"

	function automatic logic [31:0] encR(input opcode_e op, input funct_e fn,
			input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
		logic [4:0] shamt;
		shamt = 5'($urandom);
		return {op, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] encI(input opcode_e op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic checkHilo(input logic expWrite, input logic [1:0] expSel,
			input logic expRdHi, input logic expStart);
		checkBit("hiloWrite", hiloWrite, expWrite);
		checkWrSel("hiloWrSel", hiloWrSel, expSel);
		checkBit("hiloRdHi", hiloRdHi, expRdHi);
		checkBit("mdStart", mdStart, expStart);
	endtask

	task automatic testAlu();
		int idx;
		logic [4:0] rt;
		logic [31:0] word;
		for (int i = 0; i < 24; i++) begin
			rt = 5'($urandom_range(1, 31));  // Nonzero so the ALU is not idled
			if (i % 2 == 0) begin
				idx = $urandom_range(0, 15);
				word = encR(OpSpecial, rFns[idx], 5'($urandom), rt, 5'($urandom));
				sendInstr(word, 6'd0, 1'b0, ExcNone);
				checkAlu("aluOp", aluOp, rAlus[idx]);
				checkExt("extOp", extOp, ExtZero);
				checkBit("shamtSel", shamtSel, idx >= 13);
				checkBit("immSrc", immSrc, 1'b0);
				checkDst("dstSel", dstSel, DstRd);
				checkWb("wbSel", wbSel, WbAlu);
			end else begin
				idx = $urandom_range(0, 7);
				word = encI(iOps[idx], 5'($urandom), rt, 16'($urandom));
				sendInstr(word, 6'd0, 1'b0, ExcNone);
				checkAlu("aluOp", aluOp, iAlus[idx]);
				checkExt("extOp", extOp, iExts[idx]);
				checkBit("immSrc", immSrc, 1'b1);
				checkDst("dstSel", dstSel, DstRt);
				checkWb("wbSel", wbSel, (iOps[idx] == OpLui) ? WbImm : WbAlu);
			end
			checkBit("regWrite", regWrite, 1'b1);
			checkBit("hiloAccess", hiloAccess, 1'b0);
		end
	endtask

	task automatic testMem();
		for (int i = 0; i < 14; i++) begin
			sendInstr(encI(memOps[i], 5'($urandom), 5'($urandom), 16'($urandom)), 6'd0, 1'b0,
				ExcNone);
			checkMem("memSel", memSel, memSels[i]);
			checkBit("memRead", memRead, i < 8);
			checkBit("memWrite", memWrite, i >= 8);
			checkBit("llFlag", llFlag, memOps[i] == OpLl);
			checkBit("scFlag", scFlag, memOps[i] == OpSc);
			checkAlu("aluOp", aluOp, AluAdd);  // Address add
			checkBit("excValid", excValid, 1'b0);
		end
	endtask

	task automatic testHilo();
		sendInstr(encR(OpSpecial, FnMult, 5'd4, 5'd5, 5'd0), 6'd0, 1'b0, ExcNone);
		checkHilo(1'b1, 2'd2, 1'b0, 1'b1);
		checkMd("mdOp", mdOp, MdMult);
		checkBit("hiloAccess", hiloAccess, 1'b1);
		sendInstr(encR(OpSpecial, FnMthi, 5'd7, 5'd0, 5'd0), 6'd0, 1'b0, ExcNone);
		checkHilo(1'b1, 2'd1, 1'b0, 1'b0);
		checkBit("hiloAccess", hiloAccess, 1'b1);
		sendInstr(encR(OpSpecial, FnMfhi, 5'd0, 5'd0, 5'd9), 6'd0, 1'b0, ExcNone);
		checkHilo(1'b0, 2'd0, 1'b1, 1'b0);
		checkBit("hiloAccess", hiloAccess, 1'b1);
		checkWb("wbSel", wbSel, WbHiLo);
		checkBit("regWrite", regWrite, 1'b1);
		// MUL writes rd and leaves HI/LO alone
		sendInstr(encR(OpSpecial2, FnMul, 5'd2, 5'd3, 5'd4), 6'd0, 1'b0, ExcNone);
		checkHilo(1'b0, 2'd0, 1'b0, 1'b1);
		checkMd("mdOp", mdOp, MdMul);
		checkDst("dstSel", dstSel, DstRd);
		checkBit("regWrite", regWrite, 1'b1);
	endtask

	task automatic testBranch();
		logic [5:0] flags;  // {rsNeRt, rsGez, rsLtz, rsLez, rsGtz, rtZero}
		logic [31:0] word;
		logic [4:0] rs;
		logic taken;
		for (int i = 0; i < 24; i++) begin
			flags = 6'($urandom);
			rs = 5'($urandom);
			case (i % 6)
				0: begin
					word = encI(OpBeq, rs, 5'($urandom), 16'($urandom));
					taken = !flags[5];
				end
				1: begin
					word = encI(OpBne, rs, 5'($urandom), 16'($urandom));
					taken = flags[5];
				end
				2: begin
					word = encI(OpRegImm, rs, 5'd1, 16'($urandom));  // BGEZ
					taken = flags[4];
				end
				3: begin
					word = encI(OpRegImm, rs, 5'd0, 16'($urandom));  // BLTZ
					taken = flags[3];
				end
				4: begin
					word = encI(OpBlez, rs, 5'd0, 16'($urandom));
					taken = flags[2];
				end
				default: begin
					word = encI(OpBgtz, rs, 5'd0, 16'($urandom));
					taken = flags[1];
				end
			endcase
			sendInstr(word, flags, 1'b0, ExcNone);
			checkNpc("npcOp", npcOp, taken ? NpcBranch : NpcSeq);
			checkHint("brHint", brHint, HintOther);
			checkJType("jType", jType, JNone);
			checkBit("isBranch", isBranch, 1'b1);
		end
		sendInstr({OpJ, 26'($urandom)}, 6'd0, 1'b0, ExcNone);
		checkNpc("npcOp", npcOp, NpcJump);
		checkHint("brHint", brHint, HintOther);
		checkJType("jType", jType, JDirect);
		sendInstr({OpJal, 26'($urandom)}, 6'd0, 1'b0, ExcNone);
		checkNpc("npcOp", npcOp, NpcJump);
		checkHint("brHint", brHint, HintCall);
		checkJType("jType", jType, JDirect);
		checkDst("dstSel", dstSel, DstRa31);
		checkWb("wbSel", wbSel, WbLink);
		sendInstr(encR(OpSpecial, FnJr, 5'd31, 5'd0, 5'd0), 6'd0, 1'b0, ExcNone);
		checkNpc("npcOp", npcOp, NpcJumpReg);
		checkHint("brHint", brHint, HintReturn);
		checkJType("jType", jType, JRegister);
		sendInstr(encR(OpSpecial, FnJalr, 5'd12, 5'd0, 5'd31), 6'd0, 1'b0, ExcNone);
		checkNpc("npcOp", npcOp, NpcJumpReg);
		checkHint("brHint", brHint, HintOther);
		checkJType("jType", jType, JRegister);
		checkWb("wbSel", wbSel, WbLink);
	endtask

	task automatic testExceptions();
		sendInstr(encR(OpSpecial, FnBreak, 5'($urandom), 5'($urandom), 5'($urandom)), 6'd0,
			1'b0, ExcNone);
		checkBit("excValid", excValid, 1'b1);
		checkExc("excCode", excCode, ExcBp);
		sendInstr(encR(OpSpecial, FnSyscall, 5'd0, 5'd0, 5'd0), 6'd0, 1'b0, ExcNone);
		checkExc("excCode", excCode, ExcSys);
		sendInstr(32'h4200_0018, 6'd0, 1'b0, ExcNone);  // ERET
		checkBit("excValid", excValid, 1'b1);
		checkExc("excCode", excCode, ExcRi);
		sendInstr(32'h0085_0034, 6'd0, 1'b0, ExcNone);  // TEQ
		checkExc("excCode", excCode, ExcRi);
		// Fetch fault outranks both the word's own trap and RI
		sendInstr(encR(OpSpecial, FnBreak, 5'd0, 5'd0, 5'd0), 6'd0, 1'b1, ExcSys);
		checkBit("excValid", excValid, 1'b1);
		checkExc("excCode", excCode, ExcSys);
		sendInstr(32'h4200_0018, 6'd0, 1'b1, ExcBp);
		checkExc("excCode", excCode, ExcBp);
		sendInstr(encR(OpSpecial, FnMovz, 5'd3, 5'd4, 5'd5), 6'd0, 1'b0, ExcNone);
		checkBit("regWrite", regWrite, 1'b0);
		checkBit("excValid", excValid, 1'b0);
		sendInstr(encR(OpSpecial, FnMovz, 5'd3, 5'd4, 5'd5), 6'd1, 1'b0, ExcNone);
		checkBit("regWrite", regWrite, 1'b1);
	endtask

	task automatic testBackPressure();
		@(posedge clk);
		#5;
		outReady = 1'b0;
		sendInstr(encR(OpSpecial, FnSub, 5'd1, 5'd2, 5'd3), 6'd0, 1'b0, ExcNone);
		instr = encI(OpOri, 5'd1, 5'd2, 16'h00ff);  // Waits behind the stalled SUB
		inValid = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#5;
			checkBit("outValid", outValid, 1'b1);
			checkBit("inReady", inReady, 1'b0);
			checkAlu("aluOp", aluOp, AluSub);
			checkDst("dstSel", dstSel, DstRd);
		end
		outReady = 1'b1;
		@(posedge clk);  // SUB leaves, ORI enters
		#5;
		inValid = 1'b0;
		checkBit("outValid", outValid, 1'b1);
		checkAlu("aluOp", aluOp, AluOr);
		checkDst("dstSel", dstSel, DstRt);
		@(posedge clk);
		#5;
		checkBit("outValid", outValid, 1'b0);
	endtask

	initial begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	initial begin
		#(Period * (200 * NumTests + 100));
		$display("Watchdog expired before the test sequence finished");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		rst = 1'b0;
		inValid = 1'b0;
		instr = '0;
		{rsNeRt, rsGez, rsLtz, rsLez, rsGtz, rtZero} = '0;
		fetchExc = 1'b0;
		fetchExcCode = ExcNone;
		outReady = 1'b1;
		void'($urandom(Seed));
		repeat (4) @(posedge clk);
		#5;
		rst = 1'b1;
		testAlu();
		testMem();
		testHilo();
		testBranch();
		testExceptions();
		testBackPressure();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: exceptionCheck.sv
`timescale 1ns/10ps

module exceptionCheck import ctrlPkg::*; (
	input opcode_e op,
	input funct_e funct,
	input logic fetchExc,
	input excCode_e fetchExcCode,
	input logic anyKnown,
	output logic excValid,
	output excCode_e excCode
);

	logic isSpecial;
	logic knownWord;

	assign isSpecial = (op == OpSpecial);
	// SYNC, BREAK and SYSCALL drive no decoder but are legal words
	assign knownWord = anyKnown || (isSpecial && funct inside {FnSync, FnBreak, FnSyscall});

	always_comb begin
		excValid = 1'b1;
		if (fetchExc)
			excCode = fetchExcCode;   // Oldest fault wins
		else if (!knownWord)
			excCode = ExcRi;
		else if (isSpecial && funct == FnBreak)
			excCode = ExcBp;
		else if (isSpecial && funct == FnSyscall)
			excCode = ExcSys;
		else begin
			excValid = 1'b0;
			excCode = ExcNone;
		end
		// Fetch stage must always attach a cause to its fault
		assert ((excCode == ExcNone) == !excValid)
			else $error("exception flag and code disagree, code %0h", excCode);
	end

endmodule

// File: files.f
+incdir+.
ctrlPkg.sv
aluDecoder.sv
memDecoder.sv
mulDivDecoder.sv
branchUnit.sv
writebackDecoder.sv
exceptionCheck.sv
decodeStage.sv
decodeStageTb.sv

// File: memDecoder.sv
`timescale 1ns/10ps

module memDecoder import ctrlPkg::*; (
	input opcode_e op,
	output logic memWrite,
	output logic memRead,
	output memSel_e memSel,
	output logic llFlag,
	output logic scFlag,
	output logic memKnown
);

	assign memWrite = op inside {OpSb, OpSh, OpSw, OpSwl, OpSwr, OpSc};
	assign memRead = op inside {OpLb, OpLh, OpLwl, OpLw, OpLbu, OpLhu, OpLwr, OpLl};

	// Access width and alignment
	always_comb begin
		case (op)
			OpSb: memSel = MemSb;
			OpSh: memSel = MemSh;
			OpSw, OpSc: memSel = MemSw;
			OpSwl: memSel = MemSwl;
			OpSwr: memSel = MemSwr;
			OpLbu: memSel = MemLbu;
			OpLb: memSel = MemLb;
			OpLhu: memSel = MemLhu;
			OpLh: memSel = MemLh;
			OpLwl: memSel = MemLwl;
			OpLwr: memSel = MemLwr;
			default: memSel = MemLw;  // LW and LL
		endcase
	end

	assign llFlag = (op == OpLl);
	assign scFlag = (op == OpSc);    // Link bit checked in memory stage
	assign memKnown = memWrite || memRead;

endmodule

// File: mulDivDecoder.sv
`timescale 1ns/10ps

module mulDivDecoder import ctrlPkg::*; (
	input opcode_e op,
	input funct_e funct,
	output logic hiloWrite,
	output logic [1:0] hiloWrSel,
	output logic hiloRdHi,
	output logic mdStart,
	output mdOp_e mdOp,
	output logic hiloAccess,
	output logic mdKnown
);

	logic hiloMove;  // MTHI or MTLO
	logic hiloRead;  // MFHI or MFLO

	always_comb begin
		mdStart = 1'b1;
		mdOp = MdMultu;
		if (op == OpSpecial)
			case (funct)
				FnMultu: mdOp = MdMultu;
				FnMult: mdOp = MdMult;
				FnDivu: mdOp = MdDivu;
				FnDiv: mdOp = MdDiv;
				default: mdStart = 1'b0;
			endcase
		else if (op == OpSpecial2)
			case (funct)
				FnMaddu: mdOp = MdMaddu;
				FnMadd: mdOp = MdMadd;
				FnMsub: mdOp = MdMsub;
				FnMsubu: mdOp = MdMsubu;
				FnMul: mdOp = MdMul;      // Result goes to rd, HI/LO untouched
				default: mdStart = 1'b0;
			endcase
		else
			mdStart = 1'b0;
	end

	assign hiloMove = (op == OpSpecial) && (funct inside {FnMthi, FnMtlo});
	assign hiloRead = (op == OpSpecial) && (funct inside {FnMfhi, FnMflo});

	assign hiloWrite = hiloMove || (mdStart && mdOp != MdMul);
	// 2 unit result, 1 rs into HI, 0 rs into LO
	assign hiloWrSel = !hiloWrite ? 2'd0 : mdStart ? 2'd2 : (funct == FnMthi) ? 2'd1 : 2'd0;
	assign hiloRdHi = (op == OpSpecial) && (funct == FnMfhi);
	assign hiloAccess = mdStart || hiloMove || hiloRead;
	assign mdKnown = hiloAccess;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --assert -f files.f --top-module decodeStageTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VdecodeStageTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qxF "=== PASS ===" <<< "$output"; then
	exit 0
fi
exit 1

// File: writebackDecoder.sv
`timescale 1ns/10ps

module writebackDecoder import ctrlPkg::*; (
	input opcode_e op,
	input funct_e funct,
	input logic [RegWidth-1:0] rt,
	input logic rtZero,
	output logic regWrite,
	output dstSel_e dstSel,
	output wbSel_e wbSel
);

	logic isLinkBr;  // BGEZAL and BLTZAL
	logic isLoad;
	logic writes;
	logic condFail;

	assign isLinkBr = (op == OpRegImm) && (rt inside {RtBgezal, RtBltzal});
	assign isLoad = op inside {OpLb, OpLh, OpLwl, OpLw, OpLbu, OpLhu, OpLwr, OpLl};

	always_comb begin
		if (op == OpSpecial || (op == OpSpecial2 && funct == FnMul))
			dstSel = DstRd;
		else if (op == OpJal || isLinkBr)
			dstSel = DstRa31;
		else
			dstSel = DstRt;
	end

	always_comb begin
		if (isLoad)
			wbSel = WbMem;
		else if (op == OpLui)
			wbSel = WbImm;
		else if (op == OpJal || isLinkBr || (op == OpSpecial && funct == FnJalr))
			wbSel = WbLink;     // Return address
		else if (op == OpSpecial && funct inside {FnMfhi, FnMflo})
			wbSel = WbHiLo;
		else if (op == OpSc)
			wbSel = WbSc;       // Success flag
		else
			wbSel = WbAlu;
	end

	always_comb begin
		case (op)
			OpSpecial: writes = funct inside {FnAdd, FnAddu, FnSub, FnSubu, FnAnd, FnOr, FnXor,
				FnNor, FnSll, FnSrl, FnSra, FnSllv, FnSrlv, FnSrav, FnSlt, FnSltu, FnJalr,
				FnMfhi, FnMflo, FnMovz, FnMovn};
			OpSpecial2: writes = funct inside {FnClo, FnClz, FnMul};
			OpRegImm: writes = isLinkBr;
			OpJal, OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui, OpSc:
				writes = 1'b1;
			default: writes = isLoad;
		endcase
	end

	// Conditional moves drop the write when rt fails the test
	assign condFail = (op == OpSpecial) &&
		((funct == FnMovz && !rtZero) || (funct == FnMovn && rtZero));
	assign regWrite = writes && !condFail;

endmodule
